// ==== build.f ====
src/cache_pkg.sv
src/byte_lane_align.sv
src/cache_data_array.sv
src/cache_tag_store.sv
src/cache_ctrl.sv
src/cache_top.sv
dv/cache_props.sv
dv/cache_checker.sv
dv/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f build.f \
   -o cache_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cache_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

// ==== dv/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;
   import cache_pkg::*;

   localparam int wait_limit = 200;

   logic       clk;
   logic       arst_n;
   logic       enable;
   cache_req_t req;
   line_t      rdata;
   logic       ready;
   bus_req_t   bus_req;
   bus_rsp_t   bus_rsp;
   int         timeouts = 0;
   // backing store behind the bus
   logic [7:0] bus_mem [1 << addr_w];

   cache_top u_dut (
      .clk     (clk),
      .arst_n  (arst_n),
      .enable  (enable),
      .req     (req),
      .rdata   (rdata),
      .ready   (ready),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   cache_checker u_chk (
      .clk     (clk),
      .arst_n  (arst_n),
      .enable  (enable),
      .req     (req),
      .rdata   (rdata),
      .ready   (ready),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [7:0] init_byte(input logic [15:0] a);
      return a[7:0] ^ (a[15:8] * 8'd3) ^ 8'h96;
   endfunction

   function automatic cache_req_t make_req(input logic rw, input logic [3:0] size,
                                           input logic [15:0] a, input line_t d);
      cache_req_t r;
      r.rw       = rw;
      r.size     = size;
      r.addr.raw = a;
      r.wdata    = d;
      return r;
   endfunction

   // four tags on eight indices, so hits and evictions both show up
   function automatic cache_req_t random_req();
      cache_req_t r;
      r.rw                = 1'($urandom);
      r.size              = 4'(1 << ($urandom % 5));
      r.addr.fields.tag   = 7'(8'h11 * (1 + $urandom % 4));
      r.addr.fields.index = 5'($urandom % 8);
      r.addr.fields.offset = 4'($urandom);
      r.wdata             = {$urandom, $urandom, $urandom, $urandom};
      return r;
   endfunction

   // hold enable and req until ready, then release
   task automatic run_access(input cache_req_t r);
      int waited;
      waited = 0;
      if (timeouts == 0)
      begin
         @(posedge clk);
         enable <= 1'b1;
         req    <= r;
         @(negedge clk);
         while (!ready && waited < wait_limit)
         begin
            @(negedge clk);
            waited++;
         end
         if (!ready)
         begin
            timeouts++;
            $display("no ready for access at %h within %0d cycles", r.addr.raw, wait_limit);
         end
         @(posedge clk);
         enable <= 1'b0;
      end
   endtask

   // memory side, one answer per request, 2 to 6 cycles late
   initial
   begin : bus_responder
      int          delay;
      logic [15:0] base;
      logic        wr_q;
      line_t       wdata_q;
      for (int i = 0; i < (1 << addr_w); i++)
         bus_mem[i] = init_byte(16'(i));
      forever
      begin
         @(negedge clk);
         if (bus_req.en)
         begin
            base    = bus_req.addr.raw;
            wr_q    = bus_req.wr;
            wdata_q = bus_req.wdata;
            delay   = 2 + int'($urandom % 5);
            repeat (delay) @(posedge clk);
            if (!wr_q)
               for (int b = 0; b < 16; b++)
                  bus_rsp.rdata[b*8 +: 8] <= bus_mem[base + 16'(b)];
            bus_rsp.r <= 1'b1;
            @(posedge clk);
            bus_rsp.r <= 1'b0;
            if (wr_q)
               for (int b = 0; b < 16; b++)
                  bus_mem[base + 16'(b)] = wdata_q[b*8 +: 8];
            // en may stay high from write-back into fill
            repeat (2) @(posedge clk);
         end
      end
   end

   initial
   begin : main
      void'($urandom(32'h5c80_b812));
      arst_n  = 1'b0;
      enable  = 1'b0;
      req     = '0;
      bus_rsp = '0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);
      // cold miss, then a hit on the same line
      run_access(make_req(1'b0, 4'd4, 16'h1234, '0));
      run_access(make_req(1'b0, 4'd1, 16'h1238, '0));
      // every size at every offset
      for (int s = 0; s < 5; s++)
         for (int o = 0; o < 16; o++)
            run_access(make_req(1'b1, 4'(1 << s), 16'h1230 | 16'(o),
                                {$urandom, $urandom, $urandom, $urandom}));
      for (int o = 0; o < 16; o++)
         run_access(make_req(1'b0, 4'd0, 16'h1230 | 16'(o), '0));
      // same index, other tag, then back
      run_access(make_req(1'b0, 4'd2, 16'h9234, '0));
      run_access(make_req(1'b0, 4'd0, 16'h1230, '0));
      for (int n = 0; n < 300; n++)
         run_access(random_req());
      repeat (3) @(posedge clk);
      $display("mismatches=%0d timeouts=%0d assertion failures=%0d", u_chk.error_count,
               timeouts, u_dut.u_ctrl.u_props.fail_count);
      if (u_chk.error_count == 0 && timeouts == 0 && u_dut.u_ctrl.u_props.fail_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== dv/cache_checker.sv ====
`timescale 1ns/100ps

module cache_checker (
   input logic                  clk,
   input logic                  arst_n,
   input logic                  enable,
   input cache_pkg::cache_req_t req,
   input cache_pkg::line_t      rdata,
   input logic                  ready,
   input cache_pkg::bus_req_t   bus_req,
   input cache_pkg::bus_rsp_t   bus_rsp
);
   import cache_pkg::*;

   int                   error_count = 0;
   // memory as the processor should see it
   logic [7:0]           ref_mem [1 << addr_w];
   // lines the cache should be holding
   logic [tag_w-1:0]     shadow_tag [num_lines];
   logic [num_lines-1:0] shadow_valid;
   // per-access tracking
   logic                 busy;
   int                   lat;
   logic                 saw_bus;
   logic                 saw_wb;
   logic                 saw_fill;
   bus_req_t             prev_bus;
   logic                 prev_r;

   // same pattern the bus memory starts with
   function automatic logic [7:0] init_byte(input logic [15:0] a);
      return a[7:0] ^ (a[15:8] * 8'd3) ^ 8'h96;
   endfunction

   // 16 bytes from the line base moved down by the offset with zero fill
   function automatic line_t expected_read(input logic [15:0] a);
      line_t l;
      int    o;
      l = '0;
      o = int'(a[3:0]);
      for (int b = 0; b < 16; b++)
         if (b + o < 16)
            l[b*8 +: 8] = ref_mem[{a[15:4], 4'(b + o)}];
      return l;
   endfunction

   // size bytes at the offset where size 0 means a whole line and bytes past 15 drop
   task automatic apply_write(input logic [15:0] a, input logic [3:0] size, input line_t d);
      int n;
      int o;
      n = (size == 4'd0) ? 16 : int'(size);
      o = int'(a[3:0]);
      for (int b = 0; b < n; b++)
         if (b + o < 16)
            ref_mem[{a[15:4], 4'(b + o)}] = d[b*8 +: 8];
   endtask

   initial
      for (int i = 0; i < (1 << addr_w); i++)
         ref_mem[i] = init_byte(16'(i));

   // outputs compared mid-cycle where they are settled
   always @(negedge clk)
   begin : compare
      logic [index_w-1:0] idx;
      logic               exp_hit;
      logic               exp_wb;
      logic [15:0]        exp_addr;
      line_t              exp_line;
      if (!arst_n)
      begin
         if (ready || bus_req.en)
         begin
            error_count++;
            $display("ready or bus enable high during reset");
         end
         shadow_valid = '0;
         busy         = 1'b0;
         prev_bus     = '0;
         prev_r       = 1'b0;
      end
      else
      begin
         if (enable && !busy)
         begin
            busy     = 1'b1;
            lat      = 0;
            saw_bus  = 1'b0;
            saw_wb   = 1'b0;
            saw_fill = 1'b0;
         end
         else if (busy)
            lat++;
         if (bus_req.en)
            saw_bus = 1'b1;
         // request must not move until r rises
         if (prev_bus.en && !prev_r && bus_req.en && bus_req !== prev_bus)
         begin
            error_count++;
            $display("mismatch bus_req: got %h exp %h", bus_req, prev_bus);
         end
         if (bus_rsp.r && bus_req.en)
         begin
            idx = req.addr.fields.index;
            if (bus_req.wr)
            begin
               saw_wb   = 1'b1;
               exp_addr = {shadow_tag[idx], idx, 4'h0};
               exp_line = expected_read(exp_addr);
               if (bus_req.wdata !== exp_line)
               begin
                  error_count++;
                  $display("mismatch bus_req.wdata: got %h exp %h", bus_req.wdata, exp_line);
               end
            end
            else
            begin
               saw_fill = 1'b1;
               exp_addr = {req.addr.raw[15:4], 4'h0};
            end
            if (bus_req.addr.raw !== exp_addr)
            begin
               error_count++;
               $display("mismatch bus_req.addr: got %h exp %h", bus_req.addr.raw, exp_addr);
            end
         end
         if (ready)
         begin
            idx     = req.addr.fields.index;
            exp_hit = shadow_valid[idx] && (shadow_tag[idx] == req.addr.fields.tag);
            exp_wb  = shadow_valid[idx] && !exp_hit;
            if (!busy)
            begin
               error_count++;
               $display("ready pulsed with no request outstanding");
            end
            if (exp_hit && (lat != 2 || saw_bus))
            begin
               error_count++;
               $display("hit at %h took %0d cycles or used the bus", req.addr.raw, lat);
            end
            if (!exp_hit && !saw_fill)
            begin
               error_count++;
               $display("miss at %h finished without a line fill", req.addr.raw);
            end
            if (saw_wb != exp_wb)
            begin
               error_count++;
               $display("write-back at %h expected %0d but seen %0d", req.addr.raw, exp_wb,
                        saw_wb);
            end
            if (!req.rw)
            begin
               exp_line = expected_read(req.addr.raw);
               if (rdata !== exp_line)
               begin
                  error_count++;
                  $display("mismatch rdata: got %h exp %h", rdata, exp_line);
               end
            end
            else
               apply_write(req.addr.raw, req.size, req.wdata);
            // line now resident with this tag
            shadow_tag[idx]   = req.addr.fields.tag;
            shadow_valid[idx] = 1'b1;
            busy              = 1'b0;
         end
         prev_bus = bus_req;
         prev_r   = bus_rsp.r;
      end
   end

endmodule

// ==== dv/cache_props.sv ====
`timescale 1ns/100ps

module cache_props (
   input logic                clk,
   input logic                arst_n,
   input logic                ready,
   input cache_pkg::bus_req_t bus_req
);

   // failed assertions so far
   int fail_count = 0;

   // ready is a single-cycle pulse
   ready_pulse: assert property (@(posedge clk) disable iff (!arst_n) ready |=> !ready)
   else
   begin
      fail_count++;
      $error("ready stayed high for two cycles");
   end

   // a bus write is always part of an active request
   wr_needs_en: assert property (@(posedge clk) disable iff (!arst_n) bus_req.wr |-> bus_req.en)
   else
   begin
      fail_count++;
      $error("bus write strobe without bus enable");
   end

   // access completes only once the bus is released
   no_overlap: assert property (@(posedge clk) disable iff (!arst_n) !(ready && bus_req.en))
   else
   begin
      fail_count++;
      $error("ready raised while the bus request is active");
   end

endmodule

bind cache_ctrl cache_props u_props (
   .clk     (clk),
   .arst_n  (arst_n),
   .ready   (ready),
   .bus_req (bus_req)
);

// ==== src/cache_top.sv ====
`timescale 1ns/100ps

module cache_top (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enable,
   input  cache_pkg::cache_req_t req,
   output cache_pkg::line_t      rdata,
   output logic                  ready,
   output cache_pkg::bus_req_t   bus_req,
   input  cache_pkg::bus_rsp_t   bus_rsp
);
   import cache_pkg::*;

   // latched request from the controller
   cache_addr_u      addr;
   logic [3:0]       size;
   line_t            wdata;
   array_ctrl_t      ctl;

   // lookup results
   logic             hit;
   logic             evict;
   logic [tag_w-1:0] stored_tag;
   line_t            line;

   // aligner outputs into the data array
   byte_mask_t       mask;
   line_t            wline;

   cache_ctrl u_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .req        (req),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (stored_tag),
      .line       (line),
      .bus_r      (bus_rsp.r),
      .addr       (addr),
      // direction is already carried by the state encoding
      .rw         (),
      .size       (size),
      .wdata      (wdata),
      .ctl        (ctl),
      .ready      (ready),
      .bus_req    (bus_req)
   );

   cache_tag_store u_tags (
      .clk        (clk),
      .arst_n     (arst_n),
      .index      (addr.fields.index),
      .tag        (addr.fields.tag),
      .tag_wr     (ctl.tag_wr),
      .hit        (hit),
      .evict      (evict),
      .stored_tag (stored_tag)
   );

   // fill comes straight off the bus
   cache_data_array u_data (
      .clk        (clk),
      .index      (addr.fields.index),
      .ctl        (ctl),
      .mask       (mask),
      .wline      (wline),
      .fill_line  (bus_rsp.rdata),
      .line       (line)
   );

   // read side output is the stored line moved down by the offset
   byte_lane_align u_align (
      .offset     (addr.fields.offset),
      .size       (size),
      .wdata      (wdata),
      .line       (line),
      .mask       (mask),
      .wline      (wline),
      .rline      (rdata)
   );

endmodule

// ==== src/cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        enable,
   input  cache_pkg::cache_req_t       req,
   input  logic                        hit,
   input  logic                        evict,
   input  logic [cache_pkg::tag_w-1:0] victim_tag,
   input  cache_pkg::line_t            line,
   input  logic                        bus_r,
   output cache_pkg::cache_addr_u      addr,
   output logic                        rw,
   output logic [3:0]                  size,
   output cache_pkg::line_t            wdata,
   output cache_pkg::array_ctrl_t      ctl,
   output logic                        ready,
   output cache_pkg::bus_req_t         bus_req
);
   import cache_pkg::*;

   cache_state_e state;
   cache_state_e state_nxt;

   // request latch, loaded only while idle
   cache_addr_u  addr_q;
   logic         rw_q;
   logic [3:0]   size_q;
   line_t        wdata_q;

   // bus ready edge detect
   logic         bus_r_q;
   logic         bus_rise;

   // state groups used by the decode
   logic         hitting;
   logic         missing;
   logic         evicting;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= idle;
         bus_r_q <= 1'b0;
      end
      else
      begin
         state   <= state_nxt;
         bus_r_q <= bus_r;
      end
   end

   // sampled on the same edge that leaves idle
   always_ff @(posedge clk)
   begin
      if (state == idle)
      begin
         addr_q.raw <= req.addr.raw;
         rw_q       <= req.rw;
         size_q     <= req.size;
         wdata_q    <= req.wdata;
      end
   end

   // a transfer ends only on a low to high step of r
   assign bus_rise = bus_r & ~bus_r_q;

   always_comb
   begin
      state_nxt = state;
      unique case (state)
         idle:
            if (enable)
               state_nxt = req.rw ? wr : rd;
         // lookup cycle, hit and evict come straight from the tag store
         rd:
            state_nxt = hit ? rd_hit : (evict ? rd_evict : rd_miss);
         wr:
            state_nxt = hit ? wr_hit : (evict ? wr_evict : wr_miss);
         // victim written back, then go fetch the new line
         rd_evict:
            if (bus_rise)
               state_nxt = rd_miss;
         wr_evict:
            if (bus_rise)
               state_nxt = wr_miss;
         // fill lands on the same edge, then finish as a hit
         rd_miss:
            if (bus_rise)
               state_nxt = rd_hit;
         wr_miss:
            if (bus_rise)
               state_nxt = wr_hit;
         rd_hit,
         wr_hit:
            state_nxt = idle;
         default:
            state_nxt = idle;
      endcase
   end

   assign hitting  = (state == rd_hit) || (state == wr_hit);
   assign missing  = (state == rd_miss) || (state == wr_miss);
   assign evicting = (state == rd_evict) || (state == wr_evict);

   // array strobes
   assign ctl.data_wr = (state == wr_hit);
   assign ctl.fill    = missing & bus_rise;
   assign ctl.tag_wr  = hitting;

   // one-cycle pulse, the hit states last one cycle each
   assign ready = hitting;

   // bus side, held steady for the whole wait
   assign bus_req.en    = missing | evicting;
   assign bus_req.wr    = evicting;
   assign bus_req.addr.raw = {evicting ? victim_tag : addr_q.fields.tag,
                              addr_q.fields.index,
                              {offset_w{1'b0}}};
   // write-back data is the stored victim line
   assign bus_req.wdata = line;

   // latched request to the stores and aligner
   assign addr  = addr_q;
   assign rw    = rw_q;
   assign size  = size_q;
   assign wdata = wdata_q;

endmodule

// ==== src/cache_tag_store.sv ====
`timescale 1ns/100ps

module cache_tag_store (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic [cache_pkg::index_w-1:0] index,
   input  logic [cache_pkg::tag_w-1:0]   tag,
   input  logic                          tag_wr,
   output logic                          hit,
   output logic                          evict,
   output logic [cache_pkg::tag_w-1:0]   stored_tag
);
   import cache_pkg::*;

   // one tag and one valid bit per line
   logic [tag_w-1:0]     tags [num_lines];
   logic [num_lines-1:0] valid;

   logic                 line_valid;
   logic                 tag_match;

   // combinational lookup on the latched index
   assign stored_tag = tags[index];
   assign line_valid = valid[index];
   assign tag_match  = (stored_tag == tag);

   // invalid lines neither hit nor need a write-back
   assign hit   = line_valid & tag_match;
   // any valid line with a foreign tag goes back to memory
   assign evict = line_valid & ~tag_match;

   // valid bits start clear after reset
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid <= '0;
      end
      else if (tag_wr)
      begin
         // lines are never invalidated once filled
         valid[index] <= 1'b1;
      end
   end

   // new tag stored when the access completes
   always_ff @(posedge clk)
   begin
      if (tag_wr)
      begin
         tags[index] <= tag;
      end
   end

endmodule

// ==== src/cache_data_array.sv ====
`timescale 1ns/100ps

module cache_data_array (
   input  logic                          clk,
   input  logic [cache_pkg::index_w-1:0] index,
   input  cache_pkg::array_ctrl_t        ctl,
   input  cache_pkg::byte_mask_t         mask,
   input  cache_pkg::line_t              wline,
   input  cache_pkg::line_t              fill_line,
   output cache_pkg::line_t              line
);
   import cache_pkg::*;

   line_t      mem [num_lines];

   // merged write port
   byte_mask_t byte_we;
   line_t      din;

   // fill takes the whole bus line, a processor write only its masked lanes
   always_comb
   begin
      din     = ctl.fill ? fill_line : wline;
      byte_we = '0;
      if (ctl.fill)
         byte_we = '1;
      else if (ctl.data_wr)
         byte_we = mask;
   end

   // per-byte write on the clock edge
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < line_bytes; b++)
      begin
         if (byte_we[b])
            mem[index][b*8 +: 8] <= din[b*8 +: 8];
      end
   end

   // asynchronous read
   assign line = mem[index];

endmodule

// ==== src/byte_lane_align.sv ====
`timescale 1ns/100ps

module byte_lane_align (
   input  logic [cache_pkg::offset_w-1:0] offset,
   input  logic [3:0]                     size,
   input  cache_pkg::line_t               wdata,
   input  cache_pkg::line_t               line,
   output cache_pkg::byte_mask_t          mask,
   output cache_pkg::line_t               wline,
   output cache_pkg::line_t               rline
);
   import cache_pkg::*;

   // low size bits set, up to 15 lanes
   byte_mask_t          ones;
   byte_mask_t          base_mask;

   // staged shifter results
   byte_mask_t          mask_sh;
   line_t               wl_sh;
   line_t               rl_sh;

   // contiguous run of size bytes starting at lane 0
   always_comb
   begin
      ones = byte_mask_t'(1) << size;
      ones = ones - 1'b1;
      // size 0 selects the whole line
      if (size == 4'd0)
         base_mask = '1;
      else
         base_mask = ones;
   end

   // log shifter with one stage per offset bit
   // bytes pushed past lane 15 fall off the top
   always_comb
   begin
      mask_sh = base_mask;
      wl_sh   = wdata;
      rl_sh   = line;
      for (int s = 0; s < offset_w; s++)
      begin
         if (offset[s])
         begin
            mask_sh = mask_sh << (1 << s);
            // write data moves up to the addressed byte
            wl_sh   = wl_sh << (8 << s);
            // read data comes down to lane 0 with zero fill
            rl_sh   = rl_sh >> (8 << s);
         end
      end
   end

   assign mask  = mask_sh;
   assign wline = wl_sh;
   assign rline = rl_sh;

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

   // geometry of the direct-mapped cache
   // 32 lines of 16 bytes behind a 16-bit byte address
   localparam int addr_w     = 16;
   localparam int offset_w   = 4;
   localparam int index_w    = 5;
   localparam int tag_w      = 7;
   localparam int line_bytes = 16;
   localparam int num_lines  = 32;

   // one full line, byte 0 in bits 7:0
   typedef logic [line_bytes*8-1:0] line_t;

   // one write enable per byte lane
   typedef logic [line_bytes-1:0] byte_mask_t;

   // address split as tag, index, offset from msb down
   typedef struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
   } addr_fields_t;

   // same 16 bits seen as a raw word or as lookup fields
   typedef union packed {
      logic [addr_w-1:0] raw;
      addr_fields_t      fields;
   } cache_addr_u;

   // one-hot controller states
   typedef enum logic [8:0] {
      idle     = 9'b0_0000_0001,
      rd       = 9'b0_0000_0010,
      rd_hit   = 9'b0_0000_0100,
      rd_miss  = 9'b0_0000_1000,
      rd_evict = 9'b0_0001_0000,
      wr       = 9'b0_0010_0000,
      wr_hit   = 9'b0_0100_0000,
      wr_miss  = 9'b0_1000_0000,
      wr_evict = 9'b1_0000_0000
   } cache_state_e;

   // processor request, rw high for a write
   // size counts bytes, 0 stands for a whole line
   typedef struct packed {
      logic        rw;
      logic [3:0]  size;
      cache_addr_u addr;
      line_t       wdata;
   } cache_req_t;

   // line-wide memory bus, address always line aligned
   typedef struct packed {
      logic        en;
      logic        wr;
      cache_addr_u addr;
      line_t       wdata;
   } bus_req_t;

   // r is the ready strobe, a transfer ends on its rising edge
   typedef struct packed {
      logic  r;
      line_t rdata;
   } bus_rsp_t;

   // controller strobes into the tag and data stores
   typedef struct packed {
      logic data_wr;
      logic fill;
      logic tag_wr;
   } array_ctrl_t;

endpackage
